//--- logic/conv_cfg_pkg.sv
// conv_cfg_pkg
// shared constants, field types and payload layouts for the
// configuration controller of the convolution accelerator

package conv_cfg_pkg;

	localparam int CFG_WORDS    = 6;            // intake words per frame
	localparam int ACT_DEPTH    = 4096;         // activation buffer, words
	localparam int WEIGHT_DEPTH = 8192;         // weight buffer, words
	localparam logic [31:0] DDR_OFFSET = 32'h1000_0000;

	typedef logic [31:0] word_t;
	typedef logic [8:0]  img_dim_t;             // square image side
	typedef logic [11:0] chan_t;
	typedef logic [24:0] len_t;
	typedef logic [7:0]  tile_t;
	typedef logic [2:0]  tile_log_t;
	typedef logic [31:0] frame_cnt_t;

	typedef enum logic [2:0] {
		IDLE_INTAKE,
		CALC,
		SEND,
		WAIT_READY,
		FINISH
	} cfg_state_t;

	////////////////////////////////////////////////////////////////////////////
	// payloads, word 0 sits in the low 32 bits and goes out first
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		word_t       rd_bytes;                  // word 3
		word_t       act_raddr;                 // word 2
		word_t       act_waddr;                 // word 1
		logic [1:0]  rsvd;
		logic [21:0] line_len;
		tile_t       a_tile;                    // word 0
	} dm_cfg_t;

	typedef struct packed {
		word_t       sync_num;                  // word 2
		word_t       w_addr;                    // word 1
		logic [5:0]  rsvd;
		logic        workmode;
		len_t        weight_len;                // word 0
	} wm_cfg_t;

	typedef struct packed {
		logic [11:0] rsvd2;
		tile_t       w_tile;
		chan_t       och_per_tile;              // word 2
		word_t       b_addr;                    // word 1
		logic [14:0] rsvd0;
		chan_t       och;
		logic        workmode;
		logic        mode_1_1;
		logic [2:0]  flags;                     // word 0, relu/bias/bit-intercept
	} pp_cfg_t;

endpackage

//--- logic/cfg_word_counter.sv
// cfg_word_counter
// counts accepted intake words of one frame, flags the last one

`timescale 1ns/1ps

module cfg_word_counter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_clr,
	input  logic       i_step,
	output logic       o_last,
	output logic [2:0] o_count
);

	localparam logic [2:0] LAST_IDX = 3'(conv_cfg_pkg::CFG_WORDS - 1);

	assign o_last = i_step && (o_count == LAST_IDX);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_count <= '0;
		end else if (i_clr || o_last) begin
			o_count <= '0;                      // wrap for the next frame
		end else if (i_step) begin
			o_count <= o_count + 3'd1;
		end
	end

	a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_count <= LAST_IDX);

endmodule

//--- logic/cfg_fsm.sv
// cfg_fsm
// phase sequencer through intake, calculation, send, consumer wait and finish
// also collects stream done pulses and counts frames

`timescale 1ns/1ps

module cfg_fsm (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     i_cfg_valid,
	input  logic                     i_words_last,
	input  logic                     i_calc_done,
	input  logic                     i_dm_done,
	input  logic                     i_wm_done,
	input  logic                     i_pp_done,
	input  logic                     i_dm_ready,
	input  logic                     i_wm_ready,
	input  logic                     i_pp_ready,
	output logic                     o_cfg_ready,
	output logic                     o_calc_start,
	output logic                     o_send_start,
	output logic                     o_cnt_clr,
	output conv_cfg_pkg::frame_cnt_t o_frame_cnt,
	output conv_cfg_pkg::cfg_state_t o_status
);

	conv_cfg_pkg::cfg_state_t state, state_nx;
	logic [2:0] done_seen;
	logic [2:0] done_all;
	logic       intake_done;

	assign intake_done  = i_cfg_valid && o_cfg_ready && i_words_last;
	assign done_all     = done_seen | {i_dm_done, i_wm_done, i_pp_done};
	assign o_send_start = (state == conv_cfg_pkg::CALC) && i_calc_done;
	assign o_cnt_clr    = (state == conv_cfg_pkg::FINISH);
	assign o_status     = state;

	always_comb begin
		state_nx = state;
		case (state)
			conv_cfg_pkg::IDLE_INTAKE: if (intake_done) state_nx = conv_cfg_pkg::CALC;
			conv_cfg_pkg::CALC:        if (i_calc_done) state_nx = conv_cfg_pkg::SEND;
			conv_cfg_pkg::SEND:        if (&done_all) state_nx = conv_cfg_pkg::WAIT_READY;
			conv_cfg_pkg::WAIT_READY:
				if (i_dm_ready && i_wm_ready && i_pp_ready) state_nx = conv_cfg_pkg::FINISH;
			default:                   state_nx = conv_cfg_pkg::IDLE_INTAKE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= conv_cfg_pkg::IDLE_INTAKE;
			o_cfg_ready  <= 1'b0;               // held low through reset
			o_calc_start <= 1'b0;
			done_seen    <= '0;
			o_frame_cnt  <= '0;
		end else begin
			state        <= state_nx;
			o_cfg_ready  <= (state_nx == conv_cfg_pkg::IDLE_INTAKE);
			o_calc_start <= intake_done;        // fields captured by then
			if (o_send_start)
				done_seen <= '0;
			else
				done_seen <= done_all;
			if (state == conv_cfg_pkg::FINISH)
				o_frame_cnt <= o_frame_cnt + 32'd1;
		end
	end

	// calculator done only lands while CALC waits for it
	a_send_start: assert property (@(posedge clk) disable iff (!rst_n)
		i_calc_done |-> (state == conv_cfg_pkg::CALC));

endmodule

//--- logic/cfg_capture.sv
// cfg_capture
// decodes intake words by position into layer fields,
// addresses get the DDR offset on the way in

`timescale 1ns/1ps

module cfg_capture (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_load,
	input  logic [2:0]             i_index,
	input  conv_cfg_pkg::word_t    i_word,
	output logic                   o_mode_1_1,
	output logic [2:0]             o_flags,
	output conv_cfg_pkg::img_dim_t o_img,
	output conv_cfg_pkg::chan_t    o_ich,
	output conv_cfg_pkg::chan_t    o_och,
	output conv_cfg_pkg::word_t    o_act_waddr,
	output conv_cfg_pkg::word_t    o_act_raddr,
	output conv_cfg_pkg::word_t    o_w_addr,
	output conv_cfg_pkg::word_t    o_b_addr
);

	conv_cfg_pkg::word_t addr;

	assign addr = i_word + conv_cfg_pkg::DDR_OFFSET;

	// mode switches
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_mode_1_1 <= 1'b0;
			o_flags    <= '0;
		end else if (i_load && i_index == 3'd0) begin
			o_mode_1_1 <= i_word[0];           // 1x1 kernel
			o_flags    <= i_word[3:1];
		end
	end

	// dimensions and addresses
	always_ff @(posedge clk) begin
		if (i_load) begin
			case (i_index)
				3'd0: o_img <= i_word[16:8];
				3'd1: begin
					o_ich <= i_word[11:0];
					o_och <= i_word[23:12];
				end
				3'd2: o_act_waddr <= addr;
				3'd3: o_act_raddr <= addr;
				3'd4: o_w_addr    <= addr;
				3'd5: o_b_addr    <= addr;
				default: ;
			endcase
		end
	end

endmodule

//--- logic/param_calc.sv
// param_calc
// derives lengths, work mode and tile counts from the captured fields
// and packs the three consumer payloads, takes a few cycles per frame

`timescale 1ns/1ps

module param_calc (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_start,
	input  logic                   i_mode_1_1,
	input  logic [2:0]             i_flags,
	input  conv_cfg_pkg::img_dim_t i_img,
	input  conv_cfg_pkg::chan_t    i_ich,
	input  conv_cfg_pkg::chan_t    i_och,
	input  conv_cfg_pkg::word_t    i_act_waddr,
	input  conv_cfg_pkg::word_t    i_act_raddr,
	input  conv_cfg_pkg::word_t    i_w_addr,
	input  conv_cfg_pkg::word_t    i_b_addr,
	output logic                   o_done,
	output conv_cfg_pkg::dm_cfg_t  o_dm,
	output conv_cfg_pkg::wm_cfg_t  o_wm,
	output conv_cfg_pkg::pp_cfg_t  o_pp
);

	typedef enum logic [2:0] {S_IDLE, S_MUL, S_MODE, S_TILE, S_PACK, S_DONE} calc_state_t;

	calc_state_t            state;
	logic [17:0]            img_sq;
	conv_cfg_pkg::len_t     act_len;
	conv_cfg_pkg::len_t     weight_rlen;
	logic                   workmode;
	conv_cfg_pkg::tile_log_t a_log;
	conv_cfg_pkg::tile_log_t w_log;
	conv_cfg_pkg::tile_t    a_tile;
	conv_cfg_pkg::tile_t    w_tile;
	logic [25:0]            rd_bytes;
	logic [22:0]            sync_num;

	assign a_tile   = 8'd1 << a_log;
	assign w_tile   = 8'd1 << w_log;
	assign rd_bytes = {act_len, 1'b0} >> a_log;            // bytes per tile
	assign sync_num = weight_rlen[24:2] >> w_log;
	assign o_done   = (state == S_DONE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (i_start) state <= S_MUL;
				S_MUL:  state <= S_MODE;
				S_MODE: state <= S_TILE;
				S_TILE: begin
					if (!workmode) begin
						if ((act_len >> a_log) <= conv_cfg_pkg::ACT_DEPTH || a_log == 3'd7)
							state <= S_PACK;
					end else begin
						if ((weight_rlen >> w_log) <= conv_cfg_pkg::WEIGHT_DEPTH || w_log == 3'd7)
							state <= S_PACK;
					end
				end
				S_PACK: state <= S_DONE;
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				img_sq      <= i_img * i_img;
				weight_rlen <= conv_cfg_pkg::len_t'(i_ich) * conv_cfg_pkg::len_t'(i_och);
				a_log       <= '0;
				w_log       <= '0;
			end
			S_MUL: begin
				act_len <= conv_cfg_pkg::len_t'(img_sq) * conv_cfg_pkg::len_t'(i_ich);
				if (!i_mode_1_1)
					weight_rlen <= weight_rlen * 25'd9;        // 3x3 kernel
			end
			S_MODE: workmode <= (weight_rlen > conv_cfg_pkg::WEIGHT_DEPTH);
			S_TILE: begin
				// one doubling per cycle, capped at tile 128
				if (!workmode && (act_len >> a_log) > conv_cfg_pkg::ACT_DEPTH && a_log != 3'd7)
					a_log <= a_log + 3'd1;
				if (workmode && (weight_rlen >> w_log) > conv_cfg_pkg::WEIGHT_DEPTH
						&& w_log != 3'd7)
					w_log <= w_log + 3'd1;
			end
			S_PACK: begin
				o_dm.rd_bytes     <= 32'(rd_bytes);
				o_dm.act_raddr    <= i_act_raddr;
				o_dm.act_waddr    <= i_act_waddr;
				o_dm.rsvd         <= '0;
				o_dm.line_len     <= act_len[24:3];
				o_dm.a_tile       <= a_tile;
				o_wm.sync_num     <= 32'(sync_num);
				o_wm.w_addr       <= i_w_addr;
				o_wm.rsvd         <= '0;
				o_wm.workmode     <= workmode;
				o_wm.weight_len   <= weight_rlen;
				o_pp.rsvd2        <= '0;
				o_pp.w_tile       <= w_tile;
				o_pp.och_per_tile <= i_och >> w_log;
				o_pp.b_addr       <= i_b_addr;
				o_pp.rsvd0        <= '0;
				o_pp.och          <= i_och;
				o_pp.workmode     <= workmode;
				o_pp.mode_1_1     <= i_mode_1_1;
				o_pp.flags        <= i_flags;
			end
			default: ;
		endcase
	end

endmodule

//--- logic/cfg_stream_tx.sv
// cfg_stream_tx
// sends one payload as 32-bit words over valid/ready, word 0 first,
// pulses done the cycle after the last word is taken

`timescale 1ns/1ps

module cfg_stream_tx #(
	parameter type payload_t = conv_cfg_pkg::dm_cfg_t
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_start,
	input  payload_t            i_payload,
	input  logic                i_ready,
	output logic                o_valid,
	output conv_cfg_pkg::word_t o_data,
	output logic                o_done
);

	localparam int N_WORDS = $bits(payload_t) / 32;
	localparam int IDX_W   = (N_WORDS > 1) ? $clog2(N_WORDS) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_WORDS - 1);

	logic [$bits(payload_t)-1:0] shadow;
	logic [IDX_W-1:0]            idx;
	logic                        take;

	assign take   = o_valid && i_ready;
	assign o_data = shadow[idx*32 +: 32];

	always_ff @(posedge clk) begin
		if (i_start && !o_valid)
			shadow <= i_payload;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_valid <= 1'b0;
			o_done  <= 1'b0;
			idx     <= '0;
		end else begin
			o_done <= take && (idx == LAST_IDX);
			if (i_start && !o_valid) begin
				o_valid <= 1'b1;
				idx     <= '0;
			end else if (take) begin
				if (idx == LAST_IDX)
					o_valid <= 1'b0;
				else
					idx <= idx + 1'b1;
			end
		end
	end

	// word held until the consumer takes it
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

//--- logic/conv_cfg_top.sv
// conv_cfg_top
// configuration controller: word intake, parameter derivation and
// three configuration streams for data manager, weight manager, post-processor

`timescale 1ns/1ps

module conv_cfg_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     i_cfg_valid,
	output logic                     o_cfg_ready,
	input  conv_cfg_pkg::word_t      i_cfg_data,
	output logic                     o_dm_valid,
	input  logic                     i_dm_ready,
	output conv_cfg_pkg::word_t      o_dm_data,
	output logic                     o_wm_valid,
	input  logic                     i_wm_ready,
	output conv_cfg_pkg::word_t      o_wm_data,
	output logic                     o_pp_valid,
	input  logic                     i_pp_ready,
	output conv_cfg_pkg::word_t      o_pp_data,
	output conv_cfg_pkg::frame_cnt_t o_frame_cnt,
	output conv_cfg_pkg::cfg_state_t o_status
);

	logic                   cfg_accept, words_last, cnt_clr;
	logic [2:0]             word_idx;
	logic                   calc_start, calc_done, send_start;
	logic                   dm_done, wm_done, pp_done;
	logic                   mode_1_1;
	logic [2:0]             flags;
	conv_cfg_pkg::img_dim_t img;
	conv_cfg_pkg::chan_t    ich, och;
	conv_cfg_pkg::word_t    act_waddr, act_raddr, w_addr, b_addr;
	conv_cfg_pkg::dm_cfg_t  dm_cfg;
	conv_cfg_pkg::wm_cfg_t  wm_cfg;
	conv_cfg_pkg::pp_cfg_t  pp_cfg;

	assign cfg_accept = i_cfg_valid && o_cfg_ready;

	cfg_word_counter u_cnt (
		.clk(clk), .rst_n(rst_n), .i_clr(cnt_clr), .i_step(cfg_accept),
		.o_last(words_last), .o_count(word_idx)
	);

	cfg_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .i_cfg_valid(i_cfg_valid), .i_words_last(words_last),
		.i_calc_done(calc_done), .i_dm_done(dm_done), .i_wm_done(wm_done),
		.i_pp_done(pp_done), .i_dm_ready(i_dm_ready), .i_wm_ready(i_wm_ready),
		.i_pp_ready(i_pp_ready), .o_cfg_ready(o_cfg_ready), .o_calc_start(calc_start),
		.o_send_start(send_start), .o_cnt_clr(cnt_clr), .o_frame_cnt(o_frame_cnt),
		.o_status(o_status)
	);

	cfg_capture u_cap (
		.clk(clk), .rst_n(rst_n), .i_load(cfg_accept), .i_index(word_idx),
		.i_word(i_cfg_data), .o_mode_1_1(mode_1_1), .o_flags(flags), .o_img(img),
		.o_ich(ich), .o_och(och), .o_act_waddr(act_waddr), .o_act_raddr(act_raddr),
		.o_w_addr(w_addr), .o_b_addr(b_addr)
	);

	param_calc u_calc (
		.clk(clk), .rst_n(rst_n), .i_start(calc_start), .i_mode_1_1(mode_1_1),
		.i_flags(flags), .i_img(img), .i_ich(ich), .i_och(och),
		.i_act_waddr(act_waddr), .i_act_raddr(act_raddr), .i_w_addr(w_addr),
		.i_b_addr(b_addr), .o_done(calc_done), .o_dm(dm_cfg), .o_wm(wm_cfg), .o_pp(pp_cfg)
	);

	////////////////////////////////////////////////////////////////////////////
	// output streams
	////////////////////////////////////////////////////////////////////////////

	cfg_stream_tx #(.payload_t(conv_cfg_pkg::dm_cfg_t)) tx_dm (
		.clk(clk), .rst_n(rst_n), .i_start(send_start), .i_payload(dm_cfg),
		.i_ready(i_dm_ready), .o_valid(o_dm_valid), .o_data(o_dm_data), .o_done(dm_done)
	);

	cfg_stream_tx #(.payload_t(conv_cfg_pkg::wm_cfg_t)) tx_wm (
		.clk(clk), .rst_n(rst_n), .i_start(send_start), .i_payload(wm_cfg),
		.i_ready(i_wm_ready), .o_valid(o_wm_valid), .o_data(o_wm_data), .o_done(wm_done)
	);

	cfg_stream_tx #(.payload_t(conv_cfg_pkg::pp_cfg_t)) tx_pp (
		.clk(clk), .rst_n(rst_n), .i_start(send_start), .i_payload(pp_cfg),
		.i_ready(i_pp_ready), .o_valid(o_pp_valid), .o_data(o_pp_data), .o_done(pp_done)
	);

endmodule

//--- bench/conv_cfg_tb.sv
// conv_cfg_tb
// random frames into the configuration controller, a reference model
// builds the expected dm/wm/pp words, a monitor checks every handshake

`timescale 1ns/1ps

module conv_cfg_tb;

	logic                     clk;
	logic                     rst_n;
	logic                     i_cfg_valid;
	logic                     o_cfg_ready;
	conv_cfg_pkg::word_t      i_cfg_data;
	logic                     o_dm_valid, i_dm_ready;
	logic                     o_wm_valid, i_wm_ready;
	logic                     o_pp_valid, i_pp_ready;
	conv_cfg_pkg::word_t      o_dm_data, o_wm_data, o_pp_data;
	conv_cfg_pkg::frame_cnt_t o_frame_cnt;
	conv_cfg_pkg::cfg_state_t o_status;

	conv_cfg_pkg::word_t exp_w [3][4];          // expected words per stream
	int                  exp_n [3];
	int                  rx_n [3];
	int                  hold_sel;              // stream whose ready is parked, 3 = none
	logic [2:0]          vld, rdy, pend;
	conv_cfg_pkg::word_t held [3];
	int                  errors, ntests, nfail;
	logic                timed_out;

	assign vld = {o_pp_valid, o_wm_valid, o_dm_valid};
	assign rdy = {i_pp_ready, i_wm_ready, i_dm_ready};

	conv_cfg_top uut (
		.clk(clk), .rst_n(rst_n), .i_cfg_valid(i_cfg_valid), .o_cfg_ready(o_cfg_ready),
		.i_cfg_data(i_cfg_data), .o_dm_valid(o_dm_valid), .i_dm_ready(i_dm_ready),
		.o_dm_data(o_dm_data), .o_wm_valid(o_wm_valid), .i_wm_ready(i_wm_ready),
		.o_wm_data(o_wm_data), .o_pp_valid(o_pp_valid), .i_pp_ready(i_pp_ready),
		.o_pp_data(o_pp_data), .o_frame_cnt(o_frame_cnt), .o_status(o_status)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input conv_cfg_pkg::word_t exp,
			input conv_cfg_pkg::word_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	task automatic check_frame(input conv_cfg_pkg::frame_cnt_t exp,
			input conv_cfg_pkg::frame_cnt_t act);
		if (act !== exp) begin
			$display("CHECK FAILED o_frame_cnt expected %h got %h at %0t", exp, act, $time);
			errors++;
		end
	endtask

	task automatic check_state(input conv_cfg_pkg::cfg_state_t exp,
			input conv_cfg_pkg::cfg_state_t act);
		if (act !== exp) begin
			$display("CHECK FAILED o_status expected %h got %h at %0t", exp, act, $time);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s did not happen in time (at %0t)", what, $time);
		timed_out = 1'b1;
		errors++;
	endtask

	task automatic report_test(input string name, input int e0);
		ntests++;
		if (errors != e0 || timed_out)
			nfail++;
		$display("%s: %s", name, (errors == e0 && !timed_out) ? "pass" : "fail");
	endtask

	function automatic conv_cfg_pkg::word_t data_of(input int s);
		return (s == 0) ? o_dm_data : (s == 1) ? o_wm_data : o_pp_data;
	endfunction

	function automatic string name_of(input int s);
		return (s == 0) ? "o_dm_data" : (s == 1) ? "o_wm_data" : "o_pp_data";
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic build_expected(input conv_cfg_pkg::word_t w [6], input int unsigned img,
			input int unsigned ich, input int unsigned och, input int unsigned m11,
			input int unsigned flags, output int unsigned wmode);
		int unsigned act_len, wlen, a_log, w_log;
		act_len = img * img * ich;
		wlen    = m11 ? ich * och : ich * och * 9;
		wmode   = (wlen > conv_cfg_pkg::WEIGHT_DEPTH);
		a_log   = 0;
		w_log   = 0;
		if (!wmode) begin
			while ((act_len >> a_log) > conv_cfg_pkg::ACT_DEPTH && a_log < 7)
				a_log++;
		end else begin
			while ((wlen >> w_log) > conv_cfg_pkg::WEIGHT_DEPTH && w_log < 7)
				w_log++;
		end
		exp_w[0][0] = ((act_len >> 3) << 8) | (1 << a_log);
		exp_w[0][1] = w[2] + conv_cfg_pkg::DDR_OFFSET;
		exp_w[0][2] = w[3] + conv_cfg_pkg::DDR_OFFSET;
		exp_w[0][3] = (2 * act_len) >> a_log;
		exp_w[1][0] = (wmode << 25) | wlen;
		exp_w[1][1] = w[4] + conv_cfg_pkg::DDR_OFFSET;
		exp_w[1][2] = (wlen / 4) >> w_log;
		exp_w[2][0] = flags | (m11 << 3) | (wmode << 4) | (och << 5);
		exp_w[2][1] = w[5] + conv_cfg_pkg::DDR_OFFSET;
		exp_w[2][2] = (och >> w_log) | ((1 << w_log) << 12);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	// back-pressure, a parked stream stays low once all its words are in
	task automatic drive_readys();
		forever begin
			@(posedge clk);
			i_dm_ready <= rst_n && !(hold_sel == 0 && rx_n[0] == exp_n[0])
				&& ($urandom_range(0, 3) != 0);
			i_wm_ready <= rst_n && !(hold_sel == 1 && rx_n[1] == exp_n[1])
				&& ($urandom_range(0, 3) != 0);
			i_pp_ready <= rst_n && !(hold_sel == 2 && rx_n[2] == exp_n[2])
				&& ($urandom_range(0, 3) != 0);
		end
	endtask

	task automatic send_word(input conv_cfg_pkg::word_t w);
		int   gap, n;
		logic acc;
		gap = $urandom_range(0, 2);
		acc = 1'b0;
		repeat (gap) begin
			i_cfg_valid <= 1'b0;
			i_cfg_data  <= $urandom;            // junk while idle
			@(posedge clk);
		end
		i_cfg_valid <= 1'b1;
		i_cfg_data  <= w;
		for (n = 0; n < 50 && !acc; n++) begin
			@(posedge clk);
			acc = o_cfg_ready;
		end
		if (!acc)
			report_timeout("intake handshake");
	endtask

	task automatic wait_state(input conv_cfg_pkg::cfg_state_t st, input string what);
		int   n;
		logic hit;
		hit = 1'b0;
		for (n = 0; n < 400 && !hit && !timed_out; n++) begin
			@(posedge clk);
			hit = (o_status == st);
		end
		if (!hit && !timed_out)
			report_timeout(what);
	endtask

	task automatic run_frame(input int f);
		conv_cfg_pkg::word_t w [6];
		int unsigned         img, ich, och, m11, flags, wmode;
		int                  e0, n, hold;
		e0    = errors;
		img   = $urandom_range(1, 64);
		ich   = $urandom_range(1, (f % 2) ? 256 : 24);   // even frames stay in mode 0
		och   = $urandom_range(1, (f % 2) ? 256 : 24);
		m11   = $urandom_range(0, 1);
		flags = $urandom_range(0, 7);
		w[0]  = (img << 8) | (flags << 1) | m11;
		w[1]  = (och << 12) | ich;
		for (n = 2; n < 6; n++)
			w[n] = $urandom;
		build_expected(w, img, ich, och, m11, flags, wmode);
		hold = (f % 3 == 1) ? (f / 3) % 3 : 3;
		hold_sel <= hold;
		for (n = 0; n < 6 && !timed_out; n++)
			send_word(w[n]);
		i_cfg_valid <= 1'b0;
		if (!timed_out) begin
			@(posedge clk);
			check_flag("o_cfg_ready", 1'b0, o_cfg_ready);
			check_state(conv_cfg_pkg::CALC, o_status);
			if (hold != 3) begin
				wait_state(conv_cfg_pkg::WAIT_READY, "wait-ready phase");
				for (n = 0; n < 8 && !timed_out; n++) begin
					@(posedge clk);
					check_frame(f, o_frame_cnt);
					check_state(conv_cfg_pkg::WAIT_READY, o_status);
				end
				hold_sel <= 3;
			end
			wait_state(conv_cfg_pkg::IDLE_INTAKE, "end of frame");
			check_frame(f + 1, o_frame_cnt);
			for (n = 0; n < 3; n++) begin
				if (rx_n[n] != exp_n[n]) begin
					$display("%s delivered %0d of %0d words", name_of(n), rx_n[n], exp_n[n]);
					errors++;
				end
			end
		end
		report_test($sformatf("frame %0d img %0d ich %0d och %0d 1x1 %0d workmode %0d hold %0d",
			f, img, ich, och, m11, wmode, hold), e0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stream monitor
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : monitor
		int s;
		if (!rst_n) begin
			pend = '0;
		end else begin
			if (o_cfg_ready && o_status != conv_cfg_pkg::IDLE_INTAKE)
				check_flag("o_cfg_ready", 1'b0, o_cfg_ready);
			for (s = 0; s < 3; s++) begin
				if (vld[s] && o_status != conv_cfg_pkg::SEND) begin
					$display("%s valid outside the send phase at %0t", name_of(s), $time);
					errors++;
				end
				if (pend[s] && !vld[s]) begin
					$display("%s dropped valid before the word was taken", name_of(s));
					errors++;
				end else if (pend[s]) begin
					check_word(name_of(s), held[s], data_of(s));
				end
				if (o_status == conv_cfg_pkg::CALC)
					rx_n[s] <= 0;               // new frame
				if (vld[s] && rdy[s]) begin
					if (rx_n[s] >= exp_n[s]) begin
						$display("%s sent more words than expected", name_of(s));
						errors++;
					end else begin
						check_word(name_of(s), exp_w[s][rx_n[s]], data_of(s));
					end
					rx_n[s] <= rx_n[s] + 1;
				end
				pend[s] = vld[s] && !rdy[s];
				held[s] = data_of(s);
			end
		end
	end

	initial begin : main
		int f, e0, n;
		clk         = 1'b0;
		rst_n       = 1'b0;
		i_cfg_valid = 1'b0;
		i_cfg_data  = '0;
		i_dm_ready  = 1'b0;
		i_wm_ready  = 1'b0;
		i_pp_ready  = 1'b0;
		hold_sel    = 3;
		exp_n       = '{4, 3, 3};
		rx_n        = '{0, 0, 0};
		errors      = 0;
		ntests      = 0;
		nfail       = 0;
		timed_out   = 1'b0;
		void'($urandom(5749));
		fork
			drive_readys();
		join_none

		// reset behavior
		e0 = errors;
		repeat (2) @(posedge clk);
		check_flag("o_cfg_ready", 1'b0, o_cfg_ready);
		rst_n <= 1'b1;
		for (n = 0; n < 5 && o_cfg_ready !== 1'b1; n++)
			@(posedge clk);
		if (o_cfg_ready !== 1'b1)
			report_timeout("o_cfg_ready after reset");
		check_flag("o_dm_valid", 1'b0, o_dm_valid);
		check_flag("o_wm_valid", 1'b0, o_wm_valid);
		check_flag("o_pp_valid", 1'b0, o_pp_valid);
		check_state(conv_cfg_pkg::IDLE_INTAKE, o_status);
		check_frame(0, o_frame_cnt);
		report_test("reset", e0);

		for (f = 0; f < 20 && !timed_out; f++)
			run_frame(f);

		$display("summary: %0d tests, %0d failed, %0d errors", ntests, nfail, errors);
		if (errors == 0 && !timed_out)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- conv_cfg_top.f
logic/conv_cfg_pkg.sv
logic/cfg_word_counter.sv
logic/cfg_fsm.sv
logic/cfg_capture.sv
logic/param_calc.sv
logic/cfg_stream_tx.sv
logic/conv_cfg_top.sv
bench/conv_cfg_tb.sv

//--- Bender.yml
package:
  name: conv_cfg

sources:
  - logic/conv_cfg_pkg.sv
  - logic/cfg_word_counter.sv
  - logic/cfg_fsm.sv
  - logic/cfg_capture.sv
  - logic/param_calc.sv
  - logic/cfg_stream_tx.sv
  - logic/conv_cfg_top.sv
  - target: test
    files:
      - bench/conv_cfg_tb.sv
